// File: button_debounce.sv
// Fire button debouncer; all timing counts clk cycles and the raw input may be asynchronous
`timescale 1ns/1ps
`default_nettype none

module button_debounce #(
	parameter int PRESS_CYCLES   = 240000,    // Hold before a press counts
	parameter int PULSE_CYCLES   = 960000,    // Width of pressed
	parameter int LONG_CYCLES    = 33554432,  // Hold for long_hold, from first contact
	parameter int RELEASE_CYCLES = 4800000    // Quiet time before rearm
) (
	input  logic clk,
	input  logic reset,
	input  logic in,
	output logic pressed,
	output logic long_hold
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_WAIT_PRESS,
		S_PULSE,
		S_WAIT_LONG,
		S_LONG,
		S_WAIT_OFF,
		S_WAIT_LOFF
	} db_state_t;

	db_state_t   state;
	logic [2:0]  sync;       // Metastability chain
	logic        in_s;       // Synchronized button
	logic [31:0] on_count;   // Cycles since leaving idle, saturates
	logic [31:0] off_count;  // Cycles released

	assign in_s = sync[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= 3'b000;
		end else begin
			sync <= {sync[1:0], in};
		end
	end

	// Press state machine
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (in_s) state <= S_WAIT_PRESS;
				S_WAIT_PRESS: begin
					if (!in_s) state <= S_IDLE;  // Bounce, drop it
					else if (on_count == 32'(PRESS_CYCLES - 1)) state <= S_PULSE;
				end
				S_PULSE: begin
					if (on_count == 32'(PRESS_CYCLES + PULSE_CYCLES - 1)) state <= S_WAIT_LONG;
				end
				S_WAIT_LONG: begin
					if (!in_s) state <= S_WAIT_OFF;
					else if (on_count >= 32'(LONG_CYCLES - 1)) state <= S_LONG;
				end
				S_LONG: if (!in_s) state <= S_WAIT_LOFF;
				S_WAIT_OFF: begin
					if (in_s) state <= S_WAIT_LONG;  // Contact again, still the same press
					else if (off_count == 32'(RELEASE_CYCLES - 1)) state <= S_IDLE;
				end
				S_WAIT_LOFF: begin
					if (in_s) state <= S_LONG;
					else if (off_count == 32'(RELEASE_CYCLES - 1)) state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Timing counters
	always_ff @(posedge clk) begin
		if (reset) begin
			on_count  <= '0;
			off_count <= '0;
		end else begin
			if (state == S_IDLE) on_count <= '0;
			else if (on_count != '1) on_count <= on_count + 32'd1;  // Hold at max
			if (state == S_WAIT_OFF || state == S_WAIT_LOFF) off_count <= off_count + 32'd1;
			else off_count <= '0;
		end
	end

	assign pressed   = (state == S_PULSE);
	assign long_hold = (state == S_LONG) || (state == S_WAIT_LOFF);

endmodule

`default_nettype wire

// File: fire_control.sv
// Short-press and continuous-mode control; a long hold wins over a short press in the same cycle
`timescale 1ns/1ps
`default_nettype none

module fire_control (
	input  logic clk,
	input  logic reset,
	input  logic pressed,
	input  logic long_hold,
	input  logic hit_seen,
	output logic start,
	output logic continuous
);

	logic pressed_d;    // Edge detect
	logic short_press;  // One cycle per debounced press

	always_ff @(posedge clk) begin
		if (reset) begin
			pressed_d   <= 1'b0;
			short_press <= 1'b0;
			continuous  <= 1'b0;
		end else begin
			pressed_d   <= pressed;
			short_press <= pressed & ~pressed_d;
			// Latch on long hold, drop on next press or a hit
			if (long_hold) continuous <= 1'b1;
			else if (short_press || hit_seen) continuous <= 1'b0;
		end
	end

	assign start = short_press | continuous;

endmodule

`default_nettype wire

// File: hit_tracker.sv
// Result register and hit test; hit is difficulty 1 only and op_count wraps at 48 bits
`timescale 1ns/1ps
`default_nettype none

module hit_tracker import sha_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  sha_out_t     out2,
	input  logic         out2_valid,
	output mine_result_t result,
	output logic         result_valid,
	output logic         hit_seen,
	output logic [47:0]  op_count
);

	logic [7:0][31:0] proto;  // Protocol word order, H7 on top
	logic             hit;

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			proto[i] = out2.digest[i];  // Reverses packed order
		end
	end

	assign hit = (proto[7] == 32'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			result       <= '0;
			result_valid <= 1'b0;
			hit_seen     <= 1'b0;
			op_count     <= '0;
		end else begin
			result_valid <= out2_valid;
			hit_seen     <= out2_valid & hit;
			if (out2_valid) begin
				result   <= '{nonce: out2.nonce, digest: proto, hit: hit};
				op_count <= op_count + 48'd1;  // One double hash done
			end
		end
	end

endmodule

`default_nettype wire

// File: nonce_sequencer.sv
// Job sequencer for two chained cores; header must hold still while busy, nonce wraps at 32 bits
`timescale 1ns/1ps
`default_nettype none

module nonce_sequencer import sha_pkg::*; #(
	parameter logic [31:0] START_NONCE = 32'h7a33330e
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     start,
	input  logic     continuous,
	input  header_t  header,
	input  sha_out_t out1,
	input  logic     out1_valid,
	output sha_job_t job1,
	output sha_job_t job2,
	output logic     job1_valid,
	output logic     job2_valid,
	output logic     busy
);

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_BLOCK0,  // Core 1 on block 0
		SEQ_BLOCK1   // Core 1 on block 1
	} seq_state_t;

	// Second core plus the result register
	localparam int DRAIN_CYCLES = SHA_ROUNDS + 3;

	seq_state_t state;
	word_t      nonce;       // Next nonce for block 0
	word_t      nonce_swap;  // Byte order as it sits in the header
	logic       kick;        // First block 0 of a run
	logic [6:0] drain;       // Cycles until the last result leaves
	logic       send_blk1;
	logic       send_next;

	assign send_blk1  = (state == SEQ_BLOCK0) & out1_valid;
	assign job2_valid = (state == SEQ_BLOCK1) & out1_valid;
	assign send_next  = job2_valid & continuous;  // Overlap next nonce with pass 2
	assign job1_valid = kick | send_blk1 | send_next;
	assign nonce_swap = {nonce[7:0], nonce[15:8], nonce[23:16], nonce[31:24]};

	////////////////////////////////////////////////////////////
	// Block assembly
	////////////////////////////////////////////////////////////

	always_comb begin
		job1.nonce = nonce;
		if (send_blk1) begin
			job1.block = {header[16:18], nonce_swap, PAD_BLOCK1_TAIL};
			job1.mode  = MODE_REDO;  // Reuse block 0 midstate
		end else begin
			job1.block = header[0:15];
			job1.mode  = MODE_INIT;
		end
	end

	// First digest padded as a 256-bit message
	always_comb begin
		job2.block = {out1.digest, PAD_DIGEST_TAIL};
		job2.mode  = MODE_INIT;
		job2.nonce = out1.nonce;
	end

	////////////////////////////////////////////////////////////
	// Job FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SEQ_IDLE;
			nonce <= START_NONCE;
			kick  <= 1'b0;
			drain <= '0;
		end else begin
			kick <= (state == SEQ_IDLE) & start;
			if (drain != '0) drain <= drain - 7'd1;
			case (state)
				SEQ_IDLE: if (start) state <= SEQ_BLOCK0;
				SEQ_BLOCK0: begin
					if (out1_valid) begin
						state <= SEQ_BLOCK1;
						nonce <= nonce + 32'd1;  // Block 1 already took the old value
					end
				end
				SEQ_BLOCK1: begin
					if (out1_valid) begin
						if (continuous) begin
							state <= SEQ_BLOCK0;
						end else begin
							state <= SEQ_IDLE;
							drain <= 7'(DRAIN_CYCLES);
						end
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	assign busy = (state != SEQ_IDLE) || (drain != '0);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the sha_miner testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_sha_miner -f tb.f -o sim_tb

# The testbench stops with a nonzero status on failure; the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "SIMULATION PASSED" sim.log

// File: sha256_core.sv
// Iterative SHA-256 compression; out_valid 66 cycles after in_valid, only one job at a time
`timescale 1ns/1ps
`default_nettype none

module sha256_core import sha_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  sha_job_t job,
	input  logic     in_valid,
	output sha_out_t out,
	output logic     out_valid
);

	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_ROUND,
		CORE_ADD
	} core_state_t;

	core_state_t state;
	logic [5:0]  round;     // Current round index
	block_t      w;         // Schedule window, w[0] is W[t]
	digest_t     work;      // a..h
	digest_t     midstate;  // Result of last MODE_INIT job
	sha_mode_t   mode;
	word_t       tag;       // Nonce of the running job
	word_t       t1;
	word_t       t2;
	word_t       w_new;     // W[t+16]
	digest_t     base;      // Start hash of the running job
	digest_t     sum;

	////////////////////////////////////////////////////////////
	// Round functions
	////////////////////////////////////////////////////////////

	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t bsig0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t bsig1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t ssig0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t ssig1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	assign t1 = work[7] + bsig1(work[4]) + ((work[4] & work[5]) ^ (~work[4] & work[6]))
		+ round_k(round) + w[0];
	assign t2 = bsig0(work[0]) + ((work[0] & work[1]) ^ (work[0] & work[2]) ^ (work[1] & work[2]));
	assign w_new = ssig1(w[14]) + w[9] + ssig0(w[1]) + w[0];

	// Midstate only changes in CORE_ADD, so it is still the start value here
	assign base = (mode == MODE_INIT) ? H_INIT : midstate;

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			sum[i] = base[i] + work[i];
		end
	end

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= CORE_IDLE;
			round     <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			case (state)
				CORE_IDLE: begin
					if (in_valid) begin  // Load cycle
						state <= CORE_ROUND;
						round <= '0;
					end
				end
				CORE_ROUND: begin
					round <= round + 6'd1;
					if (round == 6'(SHA_ROUNDS - 1)) state <= CORE_ADD;
				end
				CORE_ADD: begin
					state     <= CORE_IDLE;  // Free again while out_valid is high
					out_valid <= 1'b1;
				end
				default: state <= CORE_IDLE;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		case (state)
			CORE_IDLE: begin
				if (in_valid) begin
					w    <= job.block;
					mode <= job.mode;
					tag  <= job.nonce;
					work <= (job.mode == MODE_INIT) ? H_INIT : midstate;
				end
			end
			CORE_ROUND: begin
				w    <= {w[1:15], w_new};  // Slide window
				work <= {t1 + t2, work[0:2], work[3] + t1, work[4:6]};
			end
			CORE_ADD: begin
				out <= '{digest: sum, nonce: tag};
				if (mode == MODE_INIT) midstate <= sum;  // REDO keeps it for the next nonce
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: sha_miner.sv
// Top level of the button-driven miner; debounce defaults assume a 48 MHz clk
`timescale 1ns/1ps
`default_nettype none

module sha_miner import sha_pkg::*; #(
	parameter logic [31:0] START_NONCE    = 32'h7a33330e,
	parameter int          PRESS_CYCLES   = 240000,    // 5 ms
	parameter int          PULSE_CYCLES   = 960000,    // 20 ms
	parameter int          LONG_CYCLES    = 33554432,  // About 0.7 s
	parameter int          RELEASE_CYCLES = 4800000    // 100 ms
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         fire_button,
	input  header_t      header,
	output mine_result_t result,
	output logic         result_valid,
	output logic [47:0]  op_count,
	output logic         continuous,
	output logic         busy
);

	logic     pressed;
	logic     long_hold;
	logic     start;
	logic     hit_seen;
	sha_job_t job1;
	sha_job_t job2;
	logic     job1_valid;
	logic     job2_valid;
	sha_out_t out1;
	sha_out_t out2;
	logic     out1_valid;
	logic     out2_valid;

	button_debounce #(
		.PRESS_CYCLES  (PRESS_CYCLES),
		.PULSE_CYCLES  (PULSE_CYCLES),
		.LONG_CYCLES   (LONG_CYCLES),
		.RELEASE_CYCLES(RELEASE_CYCLES)
	) u_debounce (
		.clk      (clk),
		.reset    (reset),
		.in       (fire_button),
		.pressed  (pressed),
		.long_hold(long_hold)
	);

	fire_control u_control (
		.clk       (clk),
		.reset     (reset),
		.pressed   (pressed),
		.long_hold (long_hold),
		.hit_seen  (hit_seen),
		.start     (start),
		.continuous(continuous)
	);

	nonce_sequencer #(
		.START_NONCE(START_NONCE)
	) u_sequencer (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.continuous(continuous),
		.header    (header),
		.out1      (out1),
		.out1_valid(out1_valid),
		.job1      (job1),
		.job2      (job2),
		.job1_valid(job1_valid),
		.job2_valid(job2_valid),
		.busy      (busy)
	);

	// Pass 1, both header blocks
	sha256_core u_sha1 (
		.clk      (clk),
		.reset    (reset),
		.job      (job1),
		.in_valid (job1_valid),
		.out      (out1),
		.out_valid(out1_valid)
	);

	// Pass 2, over the first digest
	sha256_core u_sha2 (
		.clk      (clk),
		.reset    (reset),
		.job      (job2),
		.in_valid (job2_valid),
		.out      (out2),
		.out_valid(out2_valid)
	);

	hit_tracker u_tracker (
		.clk         (clk),
		.reset       (reset),
		.out2        (out2),
		.out2_valid  (out2_valid),
		.result      (result),
		.result_valid(result_valid),
		.hit_seen    (hit_seen),
		.op_count    (op_count)
	);

endmodule

`default_nettype wire

// File: sha_pkg.sv
// SHA-256 constants and shared types; word 0 of every block and digest sits in the top bits
`default_nettype none

package sha_pkg;

	////////////////////////////////////////////////////////////
	// Basic containers
	////////////////////////////////////////////////////////////

	typedef logic [31:0]       word_t;    // One SHA word
	typedef logic [0:15][31:0] block_t;   // 512-bit message block, word 0 first
	typedef logic [0:7][31:0]  digest_t;  // H0 first
	typedef logic [0:18][31:0] header_t;  // Header words ahead of the nonce, SHA byte order

	// Core start modes
	typedef enum logic {
		MODE_INIT,  // Start from H_INIT, keep result as midstate
		MODE_REDO   // Start from midstate, midstate untouched
	} sha_mode_t;

	typedef struct packed {
		block_t    block;
		sha_mode_t mode;
		word_t     nonce;  // Tag, rides along with the job
	} sha_job_t;

	typedef struct packed {
		digest_t digest;
		word_t   nonce;
	} sha_out_t;

	typedef struct packed {
		word_t            nonce;
		logic [7:0][31:0] digest;  // Protocol order, [7] is the top word
		logic             hit;     // Difficulty 1 met
	} mine_result_t;

	////////////////////////////////////////////////////////////
	// FIPS 180-4 constants
	////////////////////////////////////////////////////////////

	localparam int SHA_ROUNDS = 64;

	localparam digest_t H_INIT = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	// Round constants, K[0] first
	localparam logic [0:63][31:0] K_TABLE = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
		32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
		32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
		32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
		32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
		32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	function automatic word_t round_k(input logic [5:0] idx);
		return K_TABLE[idx];
	endfunction

	////////////////////////////////////////////////////////////
	// Padding
	////////////////////////////////////////////////////////////

	// Block 1 tail after the nonce word, message is 640 bits
	localparam logic [0:11][31:0] PAD_BLOCK1_TAIL = {
		32'h80000000,
		{10{32'h00000000}},
		32'h00000280
	};

	// Second pass tail, message is the 256-bit first digest
	localparam logic [0:7][31:0] PAD_DIGEST_TAIL = {
		32'h80000000,
		{6{32'h00000000}},
		32'h00000100
	};

endpackage

`default_nettype wire

// File: tb.f
+incdir+.
sha_pkg.sv
button_debounce.sv
fire_control.sv
sha256_core.sv
nonce_sequencer.sv
hit_tracker.sv
sha_miner.sv
tb_sha_miner.sv

// File: tb_sha_model.svh
// SHA-256 model for the testbench; messages are whole big-endian words, included in a module body
`ifndef TB_SHA_MODEL_SVH
`define TB_SHA_MODEL_SVH

////////////////////////////////////////////////////////////
// Constants, FIPS 180-4
////////////////////////////////////////////////////////////

localparam logic [0:63][31:0] MODEL_K = {
	32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
	32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
	32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
	32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
	32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
	32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
	32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
	32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
	32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
	32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
	32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

localparam logic [255:0] MODEL_H0 = {
	32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
	32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
};

function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

// One compression, H0 and word 0 in the top bits
function automatic logic [255:0] compress(input logic [255:0] hin, input logic [511:0] blk);
	logic [31:0]  w [64];
	logic [31:0]  v [8];
	logic [31:0]  s0;
	logic [31:0]  s1;
	logic [31:0]  t1;
	logic [31:0]  t2;
	logic [255:0] hout;
	for (int t = 0; t < 16; t++) w[t] = blk[511 - 32*t -: 32];
	for (int t = 16; t < 64; t++) begin  // Schedule expansion
		s0 = ror32(w[t-15], 7) ^ ror32(w[t-15], 18) ^ (w[t-15] >> 3);
		s1 = ror32(w[t-2], 17) ^ ror32(w[t-2], 19) ^ (w[t-2] >> 10);
		w[t] = w[t-16] + s0 + w[t-7] + s1;
	end
	for (int i = 0; i < 8; i++) v[i] = hin[255 - 32*i -: 32];
	for (int t = 0; t < 64; t++) begin
		t1 = v[7] + (ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25))
			+ ((v[4] & v[5]) ^ (~v[4] & v[6])) + MODEL_K[t] + w[t];
		t2 = (ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22))
			+ ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		v[7] = v[6];
		v[6] = v[5];
		v[5] = v[4];
		v[4] = v[3] + t1;
		v[3] = v[2];
		v[2] = v[1];
		v[1] = v[0];
		v[0] = t1 + t2;
	end
	for (int i = 0; i < 8; i++) hout[255 - 32*i -: 32] = hin[255 - 32*i -: 32] + v[i];
	return hout;
endfunction

// Full hash with padding, message length in whole words
function automatic logic [255:0] sha256_words(input logic [31:0] msg [$]);
	logic [31:0]  m [$];
	logic [31:0]  bit_len;
	logic [255:0] h;
	logic [511:0] blk;
	m = msg;
	bit_len = 32'(m.size() * 32);
	m.push_back(32'h80000000);
	while (m.size() % 16 != 14) m.push_back(32'h0);
	m.push_back(32'h0);      // Length high word
	m.push_back(bit_len);
	h = MODEL_H0;
	for (int b = 0; b < m.size() / 16; b++) begin
		for (int j = 0; j < 16; j++) blk[511 - 32*j -: 32] = m[16*b + j];
		h = compress(h, blk);
	end
	return h;
endfunction

// Double hash of header plus nonce, words returned H7 on top
function automatic logic [255:0] expected_digest(input logic [0:18][31:0] hdr,
		input logic [31:0] nonce);
	logic [31:0]  msg [$];
	logic [255:0] first;
	logic [255:0] second;
	logic [255:0] proto;
	for (int i = 0; i < 19; i++) msg.push_back(hdr[i]);
	msg.push_back({nonce[7:0], nonce[15:8], nonce[23:16], nonce[31:24]});  // Nonce bytes LE
	first = sha256_words(msg);
	msg.delete();
	for (int i = 0; i < 8; i++) msg.push_back(first[255 - 32*i -: 32]);
	second = sha256_words(msg);
	for (int i = 0; i < 8; i++) proto[32*i +: 32] = second[255 - 32*i -: 32];
	return proto;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] s;
	s = x;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

`endif

// File: tb_sha_miner.sv
// Directed testbench for sha_miner; needs Verilator --timing and --assert, stops at first error
`timescale 1ns/1ps
`default_nettype none

module tb_sha_miner import sha_pkg::*; ();

	localparam logic [31:0] HIT_NONCE   = 32'h7c2bac1d;      // Genesis block nonce
	localparam logic [31:0] START_NONCE = HIT_NONCE - 32'd3;
	localparam int PRESS = 4;
	localparam int PULSE = 6;
	localparam int LONG = 40;
	localparam int RELEASE = 8;
	localparam int SHORT_HOLD = 10;   // Past PRESS, well below LONG
	localparam int LONG_HOLD = 60;
	localparam int CONT_RUN = 400;    // Continuous time before the stop press
	localparam int IDLE_WAIT = 300;
	localparam int SETTLE = 20;
	// Watchdog from press lengths, waits, 200 per single run and 132 per continuous item
	localparam int PRESS_TOTAL = 2 + 2*SHORT_HOLD + 2*LONG_HOLD;
	localparam int WAIT_TOTAL = 3*IDLE_WAIT + 100 + 2*SETTLE + CONT_RUN + 5*6;
	localparam int RUN_TOTAL = 3*200 + 132*(5 + CONT_RUN/132 + 2);
	localparam int TIMEOUT_CYCLES = 2 * (PRESS_TOTAL + WAIT_TOTAL + RUN_TOTAL);

	logic         clk;
	logic         reset;
	logic         fire_button;
	header_t      header;
	mine_result_t result;
	logic         result_valid;
	logic [47:0]  op_count;
	logic         continuous;
	logic         busy;

	logic [31:0]  rng_state;
	logic [31:0]  nonce_log [$];  // Nonces of results since last reset
	logic [255:0] model_digest;   // Model hash of the result under check
	int           hits_seen;
	int           cycle_count = 0;
	string        current_test;

	`include "tb_sha_model.svh"

	sha_miner #(
		.START_NONCE   (START_NONCE),
		.PRESS_CYCLES  (PRESS),
		.PULSE_CYCLES  (PULSE),
		.LONG_CYCLES   (LONG),
		.RELEASE_CYCLES(RELEASE)
	) u_dut (
		.clk         (clk),
		.reset       (reset),
		.fire_button (fire_button),
		.header      (header),
		.result      (result),
		.result_valid(result_valid),
		.op_count    (op_count),
		.continuous  (continuous),
		.busy        (busy)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Checking helpers
	////////////////////////////////////////////////////////////

	task automatic report_failure();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_equal(input string what, input logic [255:0] expected,
			input logic [255:0] actual);
		assert (expected === actual) else begin
			$display("Mismatch in %s on %s: expected %h actual %h", current_test, what,
				expected, actual);
			report_failure();
		end
	endtask

	task automatic check_true(input bit cond, input string text);
		assert (cond) else begin
			$display("Error in %s: %s", current_test, text);
			report_failure();
		end
	endtask

	// Every result against the model, values from the previous cycle
	always @(posedge clk) begin
		if (!reset && result_valid) begin
			model_digest = expected_digest(header, result.nonce);
			check_equal("digest", model_digest, result.digest);
			check_equal("hit", 256'(model_digest[255:224] == 32'd0), 256'(result.hit));
			nonce_log.push_back(result.nonce);
			if (result.hit) hits_seen = hits_seen + 1;
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout in %s: DUT did not finish within %0d cycles", current_test,
				TIMEOUT_CYCLES);
			report_failure();
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		nonce_log.delete();
		hits_seen = 0;
	endtask

	task automatic hold_button(input int cycles);
		@(negedge clk);
		fire_button = 1'b1;
		repeat (cycles) @(negedge clk);
		fire_button = 1'b0;
	endtask

	task automatic fill_random_header();
		for (int i = 0; i < 19; i++) begin
			rng_state = xorshift32(rng_state);
			header[i] = rng_state;
		end
	endtask

	task automatic wait_idle();
		while (busy) @(negedge clk);
		repeat (SETTLE) @(negedge clk);  // Let the last result land
	endtask

	task automatic check_nonce_run(input logic [31:0] first);
		for (int i = 0; i < nonce_log.size(); i++) begin
			check_equal("nonce", 256'(first + 32'(i)), 256'(nonce_log[i]));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_idle();
		current_test = "reset_idle";
		apply_reset();
		check_true(!busy && !continuous && !result_valid, "control outputs high after reset");
		check_equal("op_count", 256'(0), 256'(op_count));
		check_true(result == '0, "result register not cleared by reset");
		repeat (IDLE_WAIT) @(negedge clk);
		check_equal("result count", 256'(0), 256'(nonce_log.size()));
	endtask

	task automatic test_bounce();
		current_test = "bounce";
		apply_reset();
		hold_button(PRESS - 2);  // Too short to count
		repeat (100) @(negedge clk);
		check_equal("result count", 256'(0), 256'(nonce_log.size()));
		check_equal("op_count", 256'(0), 256'(op_count));
		check_true(!busy, "busy raised by a bounce");
	endtask

	task automatic test_single_press();
		current_test = "single_press";
		fill_random_header();
		apply_reset();
		hold_button(SHORT_HOLD);
		while (nonce_log.size() == 0) @(negedge clk);
		wait_idle();
		check_equal("result count", 256'(1), 256'(nonce_log.size()));
		check_equal("nonce", 256'(START_NONCE), 256'(nonce_log[0]));
		check_equal("op_count", 256'(1), 256'(op_count));
	endtask

	task automatic test_continuous_hit();
		current_test = "continuous_hit";
		// Genesis block header, SHA word order
		header = {32'h01000000, {8{32'h00000000}},
			32'h3ba3edfd, 32'h7a7b12b2, 32'h7ac72c3e, 32'h67768f61,
			32'h7fc81bc3, 32'h888a5132, 32'h3a9fb8aa, 32'h4b1e5e4a,
			32'h29ab5f49, 32'hffff001d};
		apply_reset();
		hold_button(LONG_HOLD);
		while (hits_seen == 0) @(negedge clk);
		check_equal("results before hit", 256'(4), 256'(nonce_log.size()));
		check_nonce_run(START_NONCE);
		check_equal("hit nonce", 256'(HIT_NONCE), 256'(nonce_log[3]));
		check_equal("op_count at hit", 256'(4), 256'(op_count));
		@(negedge clk);
		check_true(!continuous, "continuous still set after the hit");
		wait_idle();
		// Next nonce was already in the first core when the hit came
		check_equal("result count", 256'(5), 256'(nonce_log.size()));
		check_nonce_run(START_NONCE);
		check_equal("op_count", 256'(5), 256'(op_count));
	endtask

	task automatic test_continuous_stop();
		int count_at_idle;
		current_test = "continuous_stop";
		fill_random_header();
		apply_reset();
		hold_button(LONG_HOLD);
		repeat (CONT_RUN) @(negedge clk);
		check_true(continuous, "long press did not start continuous mode");
		hold_button(SHORT_HOLD);  // Stop press
		wait_idle();
		check_true(!continuous, "short press did not stop continuous mode");
		count_at_idle = nonce_log.size();
		check_true(count_at_idle >= 3, "too few results in continuous mode");
		repeat (IDLE_WAIT) @(negedge clk);
		check_equal("result count", 256'(count_at_idle), 256'(nonce_log.size()));
		check_nonce_run(START_NONCE);
		check_equal("op_count", 256'(count_at_idle), 256'(op_count));
	endtask

	initial begin
		reset = 1'b1;
		fire_button = 1'b0;
		header = '0;
		rng_state = 32'h6e8b;
		hits_seen = 0;
		current_test = "startup";
		test_reset_idle();
		test_bounce();
		test_single_press();
		test_continuous_hit();
		test_continuous_stop();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
